// File: rv_core_settings.svh
// data width, reset pc and register count macros
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

`define XLEN     64
`define RESET_PC 64'h0000_0000_0000_0000
`define NUM_REGS 32

`endif

// File: rv_core_pkg.sv
// instruction word union with its format views, alu operation and branch kind enums
`default_nettype none

package rv_core_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_s_fmt_t s;
    rv_b_fmt_t b;
    rv_u_fmt_t u;
    rv_j_fmt_t j;
  } rv_inst_u;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_copy_b
  } alu_op_e;

  typedef enum logic [3:0] {
    br_none,
    br_jal,
    br_jalr,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu
  } branch_e;

endpackage

`default_nettype wire

// File: rv_fetch.sv
// program counter and wishbone classic instruction fetch with redirect
`default_nettype none
`include "rv_core_settings.svh"

module rv_fetch (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_redirect_valid,
  input  wire [`XLEN-1:0]  i_redirect_pc,
  input  wire              i_ready,
  output logic             o_valid,
  output logic [31:0]      o_inst,
  output logic [`XLEN-1:0] o_pc,
  output logic             o_wb_cyc,
  output logic             o_wb_stb,
  output logic [`XLEN-1:0] o_wb_adr,
  output logic             o_wb_we,
  output logic [3:0]       o_wb_sel,
  input  wire  [31:0]      i_wb_dat,
  input  wire              i_wb_ack
);

  logic [`XLEN-1:0] pc;     // next address to fetch
  logic             stale;  // open cycle belongs to a dropped path

  assign o_wb_stb = o_wb_cyc;
  assign o_wb_we  = 1'b0;
  assign o_wb_sel = 4'b1111;
  assign o_pc     = o_wb_adr;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc       <= `RESET_PC;
      o_wb_cyc <= 1'b0;
      o_valid  <= 1'b0;
      stale    <= 1'b0;
    end else if (i_redirect_valid) begin
      pc       <= i_redirect_pc;
      o_valid  <= 1'b0;
      o_wb_cyc <= o_wb_cyc & ~i_wb_ack;  // let the open cycle finish
      stale    <= o_wb_cyc & ~i_wb_ack;
    end else if (o_wb_cyc) begin
      if (i_wb_ack) begin
        o_wb_cyc <= 1'b0;
        o_valid  <= ~stale;
        stale    <= 1'b0;
      end
    end else if (o_valid) begin
      if (i_ready) begin
        o_valid <= 1'b0;
        pc      <= pc + `XLEN'd4;
      end
    end else begin
      o_wb_cyc <= 1'b1;
    end
  end

  // address follows pc only between cycles
  always_ff @(posedge i_clk) begin
    if (!o_wb_cyc) begin
      o_wb_adr <= pc;
    end
    if (o_wb_cyc && i_wb_ack) begin
      o_inst <= i_wb_dat;
    end
  end

  // request held with a steady address until the slave acks
  a_wb_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_stb && !i_wb_ack |=> o_wb_cyc && o_wb_stb && $stable(o_wb_adr));

endmodule

`default_nettype wire

// File: rv_decode.sv
// instruction decode, immediate generation, operand select and register interlock
`default_nettype none
`include "rv_core_settings.svh"

module rv_decode
  import rv_core_pkg::*;
(
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_valid,
  input  wire  [31:0]      i_inst,
  input  wire  [`XLEN-1:0] i_pc,
  output logic             o_ready,
  input  wire              i_redirect_valid,
  input  wire  [4:0]       i_busy_rd,
  output logic [4:0]       o_rs1_addr,
  output logic [4:0]       o_rs2_addr,
  input  wire  [`XLEN-1:0] i_rs1_data,
  input  wire  [`XLEN-1:0] i_rs2_data,
  output logic             o_valid,
  output logic [`XLEN-1:0] o_pc,
  output logic [`XLEN-1:0] o_op_a,
  output logic [`XLEN-1:0] o_op_b,
  output logic [`XLEN-1:0] o_rs2_val,
  output logic [`XLEN-1:0] o_imm,
  output alu_op_e          o_alu_op,
  output branch_e          o_branch,
  output logic             o_word_cut,
  output logic [4:0]       o_rd,
  output logic             o_wen,
  output logic             o_invalid
);

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op_reg_32 = 7'b0111011;

  rv_inst_u         inst;
  logic [2:0]       f3;
  logic [6:0]       f7;
  logic [`XLEN-1:0] imm_i, imm_u, imm_b, imm_j, imm;
  logic             r_fmt_ok, alt_imm;
  logic             legal, writes, wen, word_cut, use_rs1, use_rs2;
  logic             a_pc, b_imm, b_four;
  alu_op_e          alu_op;
  branch_e          branch;

  function automatic alu_op_e alu_from_f3(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign inst       = i_inst;
  assign f3         = inst.r.funct3;
  assign f7         = inst.r.funct7;
  assign o_rs1_addr = inst.r.rs1;
  assign o_rs2_addr = inst.r.rs2;

  assign imm_i = {{(`XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
  assign imm_u = {{(`XLEN-32){inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'h000};
  assign imm_b = {{(`XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
  assign imm_j = {{(`XLEN-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  // funct7 is zero, or 0100000 for sub and sra
  assign r_fmt_ok = f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
  assign alt_imm  = f7[5] && f3 == 3'b101;  // srai, sraiw

  always_comb begin
    alu_op   = alu_add;
    branch   = br_none;
    legal    = 1'b1;
    writes   = 1'b1;
    word_cut = 1'b0;
    use_rs1  = 1'b1;
    use_rs2  = 1'b0;
    a_pc     = 1'b0;
    b_imm    = 1'b1;
    b_four   = 1'b0;
    imm      = imm_i;
    case (inst.r.opcode)
      op_lui: begin
        alu_op  = alu_copy_b;
        use_rs1 = 1'b0;
        imm     = imm_u;
      end
      op_auipc: begin
        a_pc    = 1'b1;
        use_rs1 = 1'b0;
        imm     = imm_u;
      end
      op_jal: begin
        branch  = br_jal;
        use_rs1 = 1'b0;
        a_pc    = 1'b1;
        b_four  = 1'b1;
        imm     = imm_j;
      end
      op_jalr: begin
        legal  = f3 == 3'b000;
        branch = br_jalr;
        a_pc   = 1'b1;
        b_four = 1'b1;
      end
      op_branch: begin
        legal   = f3 != 3'b010 && f3 != 3'b011;
        writes  = 1'b0;
        use_rs2 = 1'b1;
        b_imm   = 1'b0;
        imm     = imm_b;
        case (f3)
          3'b000:  branch = br_beq;
          3'b001:  branch = br_bne;
          3'b100:  branch = br_blt;
          3'b101:  branch = br_bge;
          3'b110:  branch = br_bltu;
          default: branch = br_bgeu;
        endcase
      end
      op_imm: begin
        // 6-bit shamt leaves funct7[0] free
        legal  = (f3 != 3'b001 && f3 != 3'b101) || f7[6:1] == 6'b0 ||
                 (f3 == 3'b101 && f7[6:1] == 6'b010000);
        alu_op = alu_from_f3(f3, alt_imm);
      end
      op_reg: begin
        legal   = r_fmt_ok;
        use_rs2 = 1'b1;
        b_imm   = 1'b0;
        alu_op  = alu_from_f3(f3, f7[5]);
      end
      op_imm_32: begin
        legal    = f3 == 3'b000 || (r_fmt_ok && (f3 == 3'b001 || f3 == 3'b101));
        word_cut = 1'b1;
        alu_op   = alu_from_f3(f3, alt_imm);
      end
      op_reg_32: begin
        legal    = r_fmt_ok && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101);
        word_cut = 1'b1;
        use_rs2  = 1'b1;
        b_imm    = 1'b0;
        alu_op   = alu_from_f3(f3, f7[5]);
      end
      default: begin
        legal   = 1'b0;
        use_rs1 = 1'b0;
      end
    endcase
  end

  assign wen     = legal && writes && inst.r.rd != 5'd0;
  // wait for the instruction in execute to write back
  assign o_ready = i_busy_rd == 5'd0 ||
                   !((use_rs1 && inst.r.rs1 == i_busy_rd) || (use_rs2 && inst.r.rs2 == i_busy_rd));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid & o_ready & ~i_redirect_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_pc       <= i_pc;
      o_op_a     <= a_pc ? i_pc : i_rs1_data;
      o_op_b     <= b_four ? `XLEN'd4 : (b_imm ? imm : i_rs2_data);
      o_rs2_val  <= (branch == br_jalr) ? i_rs1_data : i_rs2_data;  // jalr base
      o_imm      <= imm;
      o_alu_op   <= alu_op;
      o_branch   <= legal ? branch : br_none;
      o_word_cut <= word_cut;
      o_rd       <= wen ? inst.r.rd : 5'd0;
      o_wen      <= wen;
      o_invalid  <= ~legal;
    end
  end

  // a hazard clears after one bubble
  a_stall_one: assert property (@(posedge i_clk) disable iff (i_rst)
    !o_ready |-> (i_busy_rd != 5'd0) ##1 o_ready);

endmodule

`default_nettype wire

// File: rv_regfile.sv
// integer register file, x0 reads as zero
`default_nettype none
`include "rv_core_settings.svh"

module rv_regfile (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire  [4:0]       i_rs1_addr,
  input  wire  [4:0]       i_rs2_addr,
  output logic [`XLEN-1:0] o_rs1_data,
  output logic [`XLEN-1:0] o_rs2_data,
  input  wire              i_wen,
  input  wire  [4:0]       i_wr_addr,
  input  wire  [`XLEN-1:0] i_wr_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 0; k < `NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && i_wr_addr != 5'd0) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: rv_execute.sv
// alu, branch resolution, word cut, register write and retire report
`default_nettype none
`include "rv_core_settings.svh"

module rv_execute
  import rv_core_pkg::*;
(
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_valid,
  input  wire  [`XLEN-1:0] i_pc,
  input  wire  [`XLEN-1:0] i_op_a,
  input  wire  [`XLEN-1:0] i_op_b,
  input  wire  [`XLEN-1:0] i_rs2_val,
  input  wire  [`XLEN-1:0] i_imm,
  input  alu_op_e          i_alu_op,
  input  branch_e          i_branch,
  input  wire              i_word_cut,
  input  wire  [4:0]       i_rd,
  input  wire              i_wen,
  input  wire              i_invalid,
  output logic [4:0]       o_busy_rd,
  output logic             o_redirect_valid,
  output logic [`XLEN-1:0] o_redirect_pc,
  output logic             o_rf_wen,
  output logic [4:0]       o_rf_addr,
  output logic [`XLEN-1:0] o_rf_data,
  output logic             o_retire_valid,
  output logic [`XLEN-1:0] o_retire_pc,
  output logic [4:0]       o_retire_rd,
  output logic [`XLEN-1:0] o_retire_data,
  output logic             o_retire_invalid
);

  logic [`XLEN-1:0] sh_src, alu_res, result, target;
  logic [5:0]       shamt;
  logic             eq, lt, ltu, taken;

  // word shifts see only the low word, sign filled for sra
  assign sh_src = i_word_cut ?
                  {{(`XLEN-32){i_op_a[31] && i_alu_op == alu_sra}}, i_op_a[31:0]} : i_op_a;
  assign shamt  = i_word_cut ? {1'b0, i_op_b[4:0]} : i_op_b[5:0];

  always_comb begin
    case (i_alu_op)
      alu_add:    alu_res = i_op_a + i_op_b;
      alu_sub:    alu_res = i_op_a - i_op_b;
      alu_slt:    alu_res = {{(`XLEN-1){1'b0}}, $signed(i_op_a) < $signed(i_op_b)};
      alu_sltu:   alu_res = {{(`XLEN-1){1'b0}}, i_op_a < i_op_b};
      alu_xor:    alu_res = i_op_a ^ i_op_b;
      alu_or:     alu_res = i_op_a | i_op_b;
      alu_and:    alu_res = i_op_a & i_op_b;
      alu_sll:    alu_res = sh_src << shamt;
      alu_srl:    alu_res = sh_src >> shamt;
      alu_sra:    alu_res = $signed(sh_src) >>> shamt;
      alu_copy_b: alu_res = i_op_b;
      default:    alu_res = '0;
    endcase
  end

  assign result = i_word_cut ? {{(`XLEN-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

  assign eq  = i_op_a == i_rs2_val;
  assign lt  = $signed(i_op_a) < $signed(i_rs2_val);
  assign ltu = i_op_a < i_rs2_val;

  always_comb begin
    case (i_branch)
      br_jal, br_jalr: taken = 1'b1;
      br_beq:          taken = eq;
      br_bne:          taken = !eq;
      br_blt:          taken = lt;
      br_bge:          taken = !lt;
      br_bltu:         taken = ltu;
      br_bgeu:         taken = !ltu;
      default:         taken = 1'b0;
    endcase
  end

  // jalr carries rs1 in the rs2 slot
  assign target = (i_branch == br_jalr) ? ((i_rs2_val + i_imm) & ~`XLEN'd1) : i_pc + i_imm;

  assign o_redirect_valid = i_valid && taken && target != i_pc + `XLEN'd4;
  assign o_redirect_pc    = target;
  assign o_busy_rd        = i_valid ? i_rd : 5'd0;

  assign o_rf_wen  = i_valid & i_wen;
  assign o_rf_addr = i_rd;
  assign o_rf_data = result;

  assign o_retire_valid   = i_valid;
  assign o_retire_pc      = i_pc;
  assign o_retire_rd      = i_rd;
  assign o_retire_data    = i_wen ? result : '0;
  assign o_retire_invalid = i_invalid;

  a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rf_wen |-> o_rf_addr != 5'd0);

  // the wrong-path instruction never reaches execute
  a_redirect_flush: assert property (@(posedge i_clk) disable iff (i_rst)
    o_redirect_valid |=> !o_retire_valid);

endmodule

`default_nettype wire

// File: rv_core_top.sv
// core top level with fetch, decode, register file and execute
`default_nettype none
`include "rv_core_settings.svh"

module rv_core_top
  import rv_core_pkg::*;
(
  input  wire              i_clk,
  input  wire              i_rst,
  output logic             o_wb_cyc,
  output logic             o_wb_stb,
  output logic [`XLEN-1:0] o_wb_adr,
  output logic             o_wb_we,
  output logic [3:0]       o_wb_sel,
  input  wire  [31:0]      i_wb_dat,
  input  wire              i_wb_ack,
  output logic             o_retire_valid,
  output logic [`XLEN-1:0] o_retire_pc,
  output logic [4:0]       o_retire_rd,
  output logic [`XLEN-1:0] o_retire_data,
  output logic             o_retire_invalid
);

  logic             f_valid, d_ready;
  logic [31:0]      f_inst;
  logic [`XLEN-1:0] f_pc;
  logic             x_valid, x_word_cut, x_wen, x_invalid;
  logic [`XLEN-1:0] x_pc, x_op_a, x_op_b, x_rs2_val, x_imm;
  alu_op_e          x_alu_op;
  branch_e          x_branch;
  logic [4:0]       x_rd, x_busy_rd;
  logic             redirect_valid;
  logic [`XLEN-1:0] redirect_pc;
  logic [4:0]       rs1_addr, rs2_addr, rf_addr;
  logic [`XLEN-1:0] rs1_data, rs2_data, rf_data;
  logic             rf_wen;

  rv_fetch fetch0 (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_redirect_valid(redirect_valid), .i_redirect_pc(redirect_pc),
    .i_ready(d_ready), .o_valid(f_valid), .o_inst(f_inst), .o_pc(f_pc),
    .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
    .o_wb_we(o_wb_we), .o_wb_sel(o_wb_sel), .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack)
  );

  rv_decode decode0 (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_valid(f_valid), .i_inst(f_inst), .i_pc(f_pc), .o_ready(d_ready),
    .i_redirect_valid(redirect_valid), .i_busy_rd(x_busy_rd),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_valid(x_valid), .o_pc(x_pc), .o_op_a(x_op_a), .o_op_b(x_op_b),
    .o_rs2_val(x_rs2_val), .o_imm(x_imm), .o_alu_op(x_alu_op), .o_branch(x_branch),
    .o_word_cut(x_word_cut), .o_rd(x_rd), .o_wen(x_wen), .o_invalid(x_invalid)
  );

  rv_regfile regfile0 (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_wen(rf_wen), .i_wr_addr(rf_addr), .i_wr_data(rf_data)
  );

  rv_execute execute0 (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_valid(x_valid), .i_pc(x_pc), .i_op_a(x_op_a), .i_op_b(x_op_b),
    .i_rs2_val(x_rs2_val), .i_imm(x_imm), .i_alu_op(x_alu_op), .i_branch(x_branch),
    .i_word_cut(x_word_cut), .i_rd(x_rd), .i_wen(x_wen), .i_invalid(x_invalid),
    .o_busy_rd(x_busy_rd),
    .o_redirect_valid(redirect_valid), .o_redirect_pc(redirect_pc),
    .o_rf_wen(rf_wen), .o_rf_addr(rf_addr), .o_rf_data(rf_data),
    .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
    .o_retire_rd(o_retire_rd), .o_retire_data(o_retire_data),
    .o_retire_invalid(o_retire_invalid)
  );

endmodule

`default_nettype wire

// File: rv_core_tb.sv
// testbench with wishbone rom model, program and retire tables, retire and bus checks
`default_nettype none
`include "rv_core_settings.svh"

module rv_core_tb
  import rv_core_pkg::*;
();

  localparam int rom_words   = 64;
  localparam int seq_fetches = 16;  // bus cycles before the first taken branch

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_reg    = 7'b0110011;
  localparam logic [6:0] opc_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_reg_32 = 7'b0111011;
  localparam logic [6:0] opc_custom = 7'b0001011;  // not implemented by the core

  logic             clk = 1'b0;
  logic             rst = 1'b1;
  logic             wb_cyc, wb_stb, wb_we;
  logic [`XLEN-1:0] wb_adr;
  logic [3:0]       wb_sel;
  logic [31:0]      wb_dat = 32'h0;
  logic             wb_ack = 1'b0;
  logic             retire_valid, retire_invalid;
  logic [`XLEN-1:0] retire_pc, retire_data;
  logic [4:0]       retire_rd;

  rv_inst_u    rom [rom_words];
  logic [63:0] exp_pc_q[$];
  logic [4:0]  exp_rd_q[$];
  logic [63:0] exp_data_q[$];
  logic        exp_inv_q[$];
  logic [31:0] rng_state = 32'd2647;
  logic [1:0]  ack_wait = 2'd0;
  logic        bus_open = 1'b0;
  int          fetch_count = 0;
  int          retired = 0;
  int          cycle_count = 0;
  int          timeout_cycles = 0;

  rv_core_top dut0 (
    .i_clk(clk), .i_rst(rst),
    .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr),
    .o_wb_we(wb_we), .o_wb_sel(wb_sel), .i_wb_dat(wb_dat), .i_wb_ack(wb_ack),
    .o_retire_valid(retire_valid), .o_retire_pc(retire_pc),
    .o_retire_rd(retire_rd), .o_retire_data(retire_data),
    .o_retire_invalid(retire_invalid)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] btype_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] rom_word(input logic [63:0] adr);
    if (adr[63:8] == '0) begin
      return rom[adr[7:2]];
    end
    return 32'h0;  // unmapped, decodes as invalid
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s expected %h, got %h", $time, what, exp, got);
      $display("Test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic place(input logic [63:0] adr, input logic [31:0] word);
    rom[adr[7:2]] = word;
  endtask

  task automatic add_retire(input logic [63:0] pc, input logic [4:0] rd,
                            input logic [63:0] data, input logic inv);
    exp_pc_q.push_back(pc);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_inv_q.push_back(inv);
  endtask

  task automatic load_program();
    for (int k = 0; k < rom_words; k++) begin
      rom[k[5:0]] = {k[24:0], 7'h7f};  // invalid opcode tagged with the word index
    end
    place(`RESET_PC + 64'h00, itype_word(12'hffb, 5'd0, 3'b000, 5'd1, opc_imm));  // addi x1,-5
    place(`RESET_PC + 64'h04, utype_word(20'h80000, 5'd2, opc_lui));
    place(`RESET_PC + 64'h08, utype_word(20'h12345, 5'd3, opc_auipc));
    place(`RESET_PC + 64'h0c, itype_word(12'h024, 5'd1, 3'b001, 5'd4, opc_imm));  // slli 36
    place(`RESET_PC + 64'h10, itype_word(12'h414, 5'd2, 3'b101, 5'd5, opc_imm));  // srai 20
    place(`RESET_PC + 64'h14, itype_word(12'hfff, 5'd3, 3'b011, 5'd6, opc_imm));  // sltiu -1
    place(`RESET_PC + 64'h18, rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7, opc_reg));  // xor
    place(`RESET_PC + 64'h1c, itype_word(12'h005, 5'd7, 3'b000, 5'd8, opc_imm_32));  // addiw
    place(`RESET_PC + 64'h20, rtype_word(7'h20, 5'd8, 5'd3, 3'b000, 5'd9, opc_reg_32));  // subw
    place(`RESET_PC + 64'h24, itype_word(12'd36, 5'd0, 3'b000, 5'd10, opc_imm));
    place(`RESET_PC + 64'h28, rtype_word(7'h20, 5'd10, 5'd9, 3'b101, 5'd11, opc_reg_32));  // sraw
    place(`RESET_PC + 64'h2c, itype_word(12'd99, 5'd0, 3'b000, 5'd0, opc_imm));  // to x0
    place(`RESET_PC + 64'h30, itype_word(12'd7, 5'd0, 3'b000, 5'd12, opc_imm));
    place(`RESET_PC + 64'h34, rtype_word(7'h00, 5'd12, 5'd12, 3'b000, 5'd12, opc_reg));
    place(`RESET_PC + 64'h38, rtype_word(7'h00, 5'd12, 5'd12, 3'b000, 5'd12, opc_reg));
    place(`RESET_PC + 64'h3c, btype_word(5'd12, 5'd12, 3'b000, 13'd12));  // beq, taken
    place(`RESET_PC + 64'h40, itype_word(12'd1, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h44, itype_word(12'd2, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h48, btype_word(5'd12, 5'd12, 3'b001, 13'd8));  // bne, not taken
    place(`RESET_PC + 64'h4c, itype_word(12'd3, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h50, jtype_word(5'd14, 21'd12));
    place(`RESET_PC + 64'h54, itype_word(12'd4, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h58, itype_word(12'd5, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h5c, itype_word(12'h070, 5'd0, 3'b000, 5'd15, opc_imm));
    place(`RESET_PC + 64'h60, itype_word(12'd1, 5'd15, 3'b000, 5'd16, opc_jalr));  // odd target
    place(`RESET_PC + 64'h64, itype_word(12'd6, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h68, itype_word(12'd7, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h6c, itype_word(12'd8, 5'd0, 3'b000, 5'd13, opc_imm));
    place(`RESET_PC + 64'h70, rtype_word(7'h00, 5'd14, 5'd13, 3'b000, 5'd17, opc_reg));
    place(`RESET_PC + 64'h74, 32'h0000_0000);
    place(`RESET_PC + 64'h78, itype_word(12'h123, 5'd3, 3'b000, 5'd18, opc_custom));
    place(`RESET_PC + 64'h7c, itype_word(12'd1, 5'd17, 3'b000, 5'd18, opc_imm));
    place(`RESET_PC + 64'h80, jtype_word(5'd0, 21'd0));  // park in a loop
  endtask

  task automatic load_expected();
    add_retire(`RESET_PC + 64'h00, 5'd1, 64'hffff_ffff_ffff_fffb, 1'b0);
    add_retire(`RESET_PC + 64'h04, 5'd2, 64'hffff_ffff_8000_0000, 1'b0);
    add_retire(`RESET_PC + 64'h08, 5'd3, 64'h0000_0000_1234_5008, 1'b0);
    add_retire(`RESET_PC + 64'h0c, 5'd4, 64'hffff_ffb0_0000_0000, 1'b0);
    add_retire(`RESET_PC + 64'h10, 5'd5, 64'hffff_ffff_ffff_f800, 1'b0);
    add_retire(`RESET_PC + 64'h14, 5'd6, 64'h0000_0000_0000_0001, 1'b0);
    add_retire(`RESET_PC + 64'h18, 5'd7, 64'h0000_0000_7fff_fffb, 1'b0);
    add_retire(`RESET_PC + 64'h1c, 5'd8, 64'hffff_ffff_8000_0000, 1'b0);
    add_retire(`RESET_PC + 64'h20, 5'd9, 64'hffff_ffff_9234_5008, 1'b0);
    add_retire(`RESET_PC + 64'h24, 5'd10, 64'h0000_0000_0000_0024, 1'b0);
    add_retire(`RESET_PC + 64'h28, 5'd11, 64'hffff_ffff_f923_4500, 1'b0);  // shift 36 acts as 4
    add_retire(`RESET_PC + 64'h2c, 5'd0, 64'h0, 1'b0);
    add_retire(`RESET_PC + 64'h30, 5'd12, 64'h0000_0000_0000_0007, 1'b0);
    add_retire(`RESET_PC + 64'h34, 5'd12, 64'h0000_0000_0000_000e, 1'b0);
    add_retire(`RESET_PC + 64'h38, 5'd12, 64'h0000_0000_0000_001c, 1'b0);
    add_retire(`RESET_PC + 64'h3c, 5'd0, 64'h0, 1'b0);
    add_retire(`RESET_PC + 64'h48, 5'd0, 64'h0, 1'b0);
    add_retire(`RESET_PC + 64'h4c, 5'd13, 64'h0000_0000_0000_0003, 1'b0);
    add_retire(`RESET_PC + 64'h50, 5'd14, `RESET_PC + 64'h54, 1'b0);
    add_retire(`RESET_PC + 64'h5c, 5'd15, 64'h0000_0000_0000_0070, 1'b0);
    add_retire(`RESET_PC + 64'h60, 5'd16, `RESET_PC + 64'h64, 1'b0);
    add_retire(`RESET_PC + 64'h70, 5'd17, `RESET_PC + 64'h57, 1'b0);  // 3 plus link of jal
    add_retire(`RESET_PC + 64'h74, 5'd0, 64'h0, 1'b1);
    add_retire(`RESET_PC + 64'h78, 5'd0, 64'h0, 1'b1);
    add_retire(`RESET_PC + 64'h7c, 5'd18, `RESET_PC + 64'h58, 1'b0);
  endtask

  task automatic check_bus_start();
    check_value("wishbone write enable", 64'(wb_we), 64'd0);
    check_value("wishbone byte select", 64'(wb_sel), 64'hf);  // full 32-bit word
    if (fetch_count < seq_fetches) begin
      check_value($sformatf("bus cycle %0d address", fetch_count), wb_adr,
                  `RESET_PC + 64'(4 * fetch_count));
    end
    fetch_count++;
  endtask

  task automatic wait_for_retire();
    @(negedge clk);
    while (!retire_valid) begin
      @(negedge clk);
    end
  endtask

  // rom slave, ack 0 to 3 cycles after stb
  always @(negedge clk) begin
    if (rst) begin
      wb_ack   = 1'b0;
      bus_open = 1'b0;
    end else if (wb_ack) begin
      check_value("wishbone cyc after ack", 64'(wb_cyc), 64'd0);
      wb_ack   = 1'b0;
      bus_open = 1'b0;
    end else if (wb_stb) begin
      check_value("wishbone cyc with stb", 64'(wb_cyc), 64'd1);
      if (!bus_open) begin
        bus_open  = 1'b1;
        rng_state = xorshift32(rng_state);
        ack_wait  = rng_state[1:0];
        check_bus_start();
      end
      if (ack_wait == 2'd0) begin
        wb_ack = 1'b1;
        wb_dat = rom_word(wb_adr);
      end else begin
        ack_wait = ack_wait - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: %0d of %0d instructions retired within %0d cycles",
               retired, exp_pc_q.size(), timeout_cycles);
      $display("Test failed");
      $fatal(1, "simulation ran out of cycles");
    end
  end

  initial begin
    load_program();
    load_expected();
    timeout_cycles = exp_pc_q.size() * 8 + 20;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < exp_pc_q.size(); n++) begin
      wait_for_retire();
      check_value($sformatf("retire %0d pc", n), retire_pc, exp_pc_q[n]);
      check_value($sformatf("retire %0d rd", n), 64'(retire_rd), 64'(exp_rd_q[n]));
      check_value($sformatf("retire %0d data", n), retire_data, exp_data_q[n]);
      check_value($sformatf("retire %0d invalid", n), 64'(retire_invalid),
                  64'(exp_inv_q[n]));
      retired = n + 1;
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core_top.f
+incdir+.
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core_top.sv
rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core_top.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Test completed successfully

SIM  := $(MDIR)/V$(TOP)
SRCS := $(wildcard *.sv *.svh)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
